// File: all.f
+incdir+logic
+incdir+verif
logic/pruner_pkg.sv
logic/row_tables.sv
logic/row_latch_stage.sv
logic/prefix_search_stage.sv
logic/residual_stage.sv
logic/pruner_top.sv
verif/pruner_tb.sv

// File: Makefile
# Verilator flow for the row pruner

VERILATOR  ?= verilator
TOP        ?= pruner_tb
LINT_TOP   ?= pruner_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Result comes from the simulation output, not the exit code
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/pruner_ref_model.svh
// Pruner reference model and LCG

`ifndef PRUNER_REF_MODEL_SVH
`define PRUNER_REF_MODEL_SVH

// Shadow copies of both tables
no_t         ref_no [0:`PRUNER_ROWS-1];
pattern_t    ref_sp [0:`PRUNER_ROWS-1];
int unsigned lcg_state = 53507;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 12;
endfunction

// Best prefix row, the row itself when nothing qualifies
function automatic row_idx_t ref_prefix(row_idx_t r);
    row_idx_t best;
    logic     found;
    logic     subset;
    logic     same;
    best  = r;
    found = 1'b0;
    for (int j = 0; j < `PRUNER_ROWS; j++) begin
        subset = ((ref_sp[j] | ref_sp[r]) == ref_sp[r]) && (ref_sp[j] != ref_sp[r]) &&
                 (ref_no[j] < ref_no[r]);
        same   = (ref_sp[j] == ref_sp[r]) && (ref_no[j] == ref_no[r]) && (j < int'(r));
        if (subset || same) begin
            // Larger count first, then the larger index
            if (!found || (ref_no[j] > ref_no[best]) ||
                ((ref_no[j] == ref_no[best]) && (j > int'(best)))) begin
                best = row_idx_t'(j);
            end
            found = 1'b1;
        end
    end
    return best;
endfunction

function automatic pattern_t ref_residual(row_idx_t r);
    row_idx_t p;
    p = ref_prefix(r);
    return (p == r) ? ref_sp[r] : (ref_sp[r] ^ ref_sp[p]);
endfunction

// Sparse random patterns, count is the popcount
task automatic fill_random();
    for (int i = 0; i < `PRUNER_ROWS; i++) begin
        ref_sp[i] = pattern_t'(lcg_next() & 32'h0000_00FF);
        ref_no[i] = no_t'($countones(ref_sp[i]));
    end
endtask

`endif

// File: verif/pruner_tb.sv
// Row pruner testbench

`include "pruner_consts.svh"

`default_nettype none

module pruner_tb import pruner_pkg::*; ();

    localparam int ROWS    = `PRUNER_ROWS;
    localparam int TIMEOUT = 400;

    logic       clk;
    logic       rst_n;
    row_idx_t   row_index;
    no_t        row_no;
    logic       row_valid;
    wire        pruner_ready;
    row_idx_t   prefix_id;
    row_idx_t   row_id_out;
    pattern_t   pattern;
    wire        prune_valid;
    wire        prune_done;
    logic       dispatch_ready;
    row_idx_t   mem_addr;
    table_sel_e mem_sel;
    logic       mem_wr_en;
    no_t        mem_no_in;
    pattern_t   mem_spike_in;
    no_t        mem_no_out;
    pattern_t   mem_spike_out;

    row_idx_t   exp_q [$];
    row_idx_t   got_prefix  [0:ROWS-1];
    pattern_t   got_pattern [0:ROWS-1];
    string      cur_test;
    int         err_count = 0;
    int         start_errors;
    int         tests_run = 0;
    int         tests_failed = 0;
    logic       bp_mode;

    `include "pruner_ref_model.svh"

    pruner_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_idx(string what, row_idx_t exp, row_idx_t act);
        if (exp !== act) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_pattern(string what, pattern_t exp, pattern_t act);
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_no(string what, no_t exp, no_t act);
        if (exp !== act) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout in %s: %s", cur_test, what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic write_entry(table_sel_e sel, row_idx_t addr, no_t no, pattern_t sp);
        mem_sel      = sel;
        mem_addr     = addr;
        mem_no_in    = no;
        mem_spike_in = sp;
        mem_wr_en    = 1'b1;
        @(posedge clk);
        #1 mem_wr_en = 1'b0;
    endtask

    task automatic load_tables();
        for (int i = 0; i < ROWS; i++) begin
            write_entry(TABLE_NO, row_idx_t'(i), ref_no[i], '0);
            write_entry(TABLE_SPIKE, row_idx_t'(i), '0, ref_sp[i]);
        end
    endtask

    // Rows 0 to 5 exercise the rules
    // Remaining rows have count 8 and never qualify as a prefix here
    task automatic load_directed();
        for (int i = 0; i < ROWS; i++) begin
            ref_sp[i] = {~8'(i), 8'(i)};
            ref_no[i] = 8'd8;
        end
        ref_sp[0] = 16'h0001;
        ref_no[0] = 8'd1;
        ref_sp[1] = 16'h0003;
        ref_no[1] = 8'd2;
        ref_sp[2] = 16'h0007;
        ref_no[2] = 8'd3;
        ref_sp[3] = 16'h0007;
        ref_no[3] = 8'd3;
        ref_sp[4] = 16'h0030;
        ref_no[4] = 8'd2;
        ref_sp[5] = 16'h0033;
        ref_no[5] = 8'd4;
        load_tables();
    endtask

    // Holds the row until the pruner takes it
    task automatic send_row(row_idx_t idx);
        int n;
        n         = 0;
        row_index = idx;
        row_no    = ref_no[idx];
        row_valid = 1'b1;
        exp_q.push_back(idx);
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("row was never accepted");
        end while (!pruner_ready);
        #1 row_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) report_timeout("expected outputs never arrived");
        end
        // One more edge so the done pulse gets sampled
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(string name);
        cur_test     = name;
        start_errors = err_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (err_count == start_errors) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, err_count - start_errors);
        end
    endtask

    // Dispatcher with random stalls in back-pressure mode
    initial begin
        dispatch_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1 dispatch_ready = bp_mode ? ((lcg_next() % 3) != 0) : 1'b1;
        end
    end

    // Output scoreboard with hold, ready and done checks
    initial begin
        row_idx_t r;
        int       acc_total;
        logic     done_exp;
        logic     held;
        row_idx_t held_row;
        row_idx_t held_prefix;
        pattern_t held_pattern;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                acc_total = 0;
                done_exp  = 1'b0;
                held      = 1'b0;
            end else begin
                check_flag("prune_done", done_exp, prune_done);
                check_flag("pruner_ready", !(prune_valid && !dispatch_ready), pruner_ready);
                if (held) begin
                    check_idx("held row_id_out", held_row, row_id_out);
                    check_idx("held prefix_id", held_prefix, prefix_id);
                    check_pattern("held pattern", held_pattern, pattern);
                end
                done_exp = 1'b0;
                if (prune_valid && dispatch_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Unexpected output for row %0d in %s", row_id_out, cur_test);
                        err_count++;
                    end else begin
                        r = exp_q.pop_front();
                        check_idx("row_id_out", r, row_id_out);
                        check_idx("prefix_id", ref_prefix(r), prefix_id);
                        check_pattern("pattern", ref_residual(r), pattern);
                        got_prefix[row_id_out]  = prefix_id;
                        got_pattern[row_id_out] = pattern;
                    end
                    acc_total++;
                    done_exp = ((acc_total % ROWS) == 0);
                end
                held         = prune_valid && !dispatch_ready;
                held_row     = row_id_out;
                held_prefix  = prefix_id;
                held_pattern = pattern;
            end
        end
    end

    task automatic test_table_readback();
        start_test("table_readback");
        fill_random();
        load_tables();
        for (int i = 0; i < ROWS; i++) begin
            mem_addr = row_idx_t'(i);
            mem_sel  = TABLE_NO;
            @(posedge clk);
            check_no("no readback", ref_no[i], mem_no_out);
            check_pattern("spike while no selected", '0, mem_spike_out);
            #1 mem_sel = TABLE_SPIKE;
            @(posedge clk);
            check_pattern("spike readback", ref_sp[i], mem_spike_out);
            check_no("no while spike selected", '0, mem_no_out);
            #1;
        end
        finish_test();
    endtask

    task automatic test_root_row();
        int n;
        start_test("root_row");
        load_directed();
        send_row(row_idx_t'(0));
        // Acceptance edge to first valid edge
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("prune_valid never rose");
        end while (!prune_valid);
        check_flag("valid three edges after acceptance", 1'b1, n == 3);
        #1;
        wait_drain();
        check_idx("root prefix", row_idx_t'(0), got_prefix[0]);
        check_pattern("root residual", 16'h0001, got_pattern[0]);
        finish_test();
    endtask

    task automatic test_prefix_rules();
        start_test("prefix_rules");
        load_directed();
        for (int i = 0; i < 6; i++) begin
            send_row(row_idx_t'(i));
        end
        wait_drain();
        check_idx("larger subset wins", row_idx_t'(1), got_prefix[2]);
        check_idx("earlier identical row", row_idx_t'(2), got_prefix[3]);
        check_idx("tie picks larger index", row_idx_t'(4), got_prefix[5]);
        check_pattern("subset residual", 16'h0004, got_pattern[2]);
        check_pattern("identical residual", 16'h0000, got_pattern[3]);
        check_pattern("tie residual", 16'h0003, got_pattern[5]);
        finish_test();
    endtask

    task automatic test_stream(string name, logic with_stalls);
        start_test(name);
        apply_reset();
        lcg_state = 53507;
        fill_random();
        load_tables();
        bp_mode = with_stalls;
        for (int i = 0; i < ROWS; i++) begin
            send_row(row_idx_t'(i));
        end
        wait_drain();
        bp_mode = 1'b0;
        finish_test();
    endtask

    initial begin
        rst_n        = 1'b0;
        row_valid    = 1'b0;
        row_index    = '0;
        row_no       = '0;
        bp_mode      = 1'b0;
        mem_addr     = '0;
        mem_sel      = TABLE_NO;
        mem_wr_en    = 1'b0;
        mem_no_in    = '0;
        mem_spike_in = '0;
        apply_reset();
        test_table_readback();
        test_root_row();
        test_prefix_rules();
        test_stream("full_stream", 1'b0);
        test_stream("back_pressure", 1'b1);
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/pruner_top.sv
// Row pruner top level

`include "pruner_consts.svh"

`default_nettype none

module pruner_top import pruner_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,

    // Row input
    input  row_idx_t   row_index,
    input  no_t        row_no,
    input  wire        row_valid,
    output wire        pruner_ready,

    // Output to the dispatcher
    output row_idx_t   prefix_id,
    output row_idx_t   row_id_out,
    output pattern_t   pattern,
    output wire        prune_valid,
    output wire        prune_done,
    input  wire        dispatch_ready,

    // Memory port
    input  row_idx_t   mem_addr,
    input  table_sel_e mem_sel,
    input  wire        mem_wr_en,
    input  no_t        mem_no_in,
    input  pattern_t   mem_spike_in,
    output no_t        mem_no_out,
    output pattern_t   mem_spike_out
);

    wire      advance;
    no_t      no_all     [0:`PRUNER_ROWS-1];
    pattern_t spikes_all [0:`PRUNER_ROWS-1];

    wire      s0_valid;
    row_idx_t s0_row;
    no_t      s0_no;
    pattern_t s0_spikes;

    wire      s1_valid;
    row_idx_t s1_row;
    pattern_t s1_spikes;
    row_idx_t s1_prefix;
    pattern_t s1_prefix_spikes;

    // Source may present a row whenever the pipe moves
    assign pruner_ready = advance;

    row_tables u_tables (
        .clk           (clk),
        .mem_addr      (mem_addr),
        .mem_sel       (mem_sel),
        .mem_wr_en     (mem_wr_en),
        .mem_no_in     (mem_no_in),
        .mem_spike_in  (mem_spike_in),
        .mem_no_out    (mem_no_out),
        .mem_spike_out (mem_spike_out),
        .no_all        (no_all),
        .spikes_all    (spikes_all)
    );

    row_latch_stage u_stage0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .row_valid  (row_valid),
        .row_index  (row_index),
        .row_no     (row_no),
        .spikes_all (spikes_all),
        .s0_valid   (s0_valid),
        .s0_row     (s0_row),
        .s0_no      (s0_no),
        .s0_spikes  (s0_spikes)
    );

    prefix_search_stage u_stage1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .advance          (advance),
        .s0_valid         (s0_valid),
        .s0_row           (s0_row),
        .s0_no            (s0_no),
        .s0_spikes        (s0_spikes),
        .no_all           (no_all),
        .spikes_all       (spikes_all),
        .s1_valid         (s1_valid),
        .s1_row           (s1_row),
        .s1_spikes        (s1_spikes),
        .s1_prefix        (s1_prefix),
        .s1_prefix_spikes (s1_prefix_spikes)
    );

    residual_stage u_stage2 (
        .clk              (clk),
        .rst_n            (rst_n),
        .s1_valid         (s1_valid),
        .s1_row           (s1_row),
        .s1_spikes        (s1_spikes),
        .s1_prefix        (s1_prefix),
        .s1_prefix_spikes (s1_prefix_spikes),
        .dispatch_ready   (dispatch_ready),
        .advance          (advance),
        .prune_valid      (prune_valid),
        .row_id_out       (row_id_out),
        .prefix_id        (prefix_id),
        .pattern          (pattern),
        .prune_done       (prune_done)
    );

endmodule

`default_nettype wire

// File: logic/residual_stage.sv
// Stage 2, residual and output handshake

`include "pruner_consts.svh"

`default_nettype none

module residual_stage import pruner_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // From stage 1
    input  wire      s1_valid,
    input  row_idx_t s1_row,
    input  pattern_t s1_spikes,
    input  row_idx_t s1_prefix,
    input  pattern_t s1_prefix_spikes,

    // Dispatcher side
    input  wire      dispatch_ready,
    output wire      advance,
    output logic     prune_valid,
    output row_idx_t row_id_out,
    output row_idx_t prefix_id,
    output pattern_t pattern,
    output logic     prune_done
);

    out_count_t out_count;
    logic       accepted;

    // Stall only while a full output sits unaccepted
    assign advance  = !prune_valid || dispatch_ready;
    assign accepted = prune_valid && dispatch_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prune_valid <= 1'b0;
        end else if (advance) begin
            prune_valid <= s1_valid;
        end
    end

    // Output registers, held while stalled
    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            row_id_out <= s1_row;
            prefix_id  <= s1_prefix;
            pattern    <= s1_spikes ^ s1_prefix_spikes;
        end
    end

    // Done pulse on every N-th accepted output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_count  <= '0;
            prune_done <= 1'b0;
        end else begin
            prune_done <= 1'b0;
            if (accepted) begin
                if (out_count == out_count_t'(`PRUNER_ROWS - 1)) begin
                    out_count  <= '0;
                    prune_done <= 1'b1;
                end else begin
                    out_count <= out_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/prefix_search_stage.sv
// Stage 1, prefix search

`include "pruner_consts.svh"

`default_nettype none

module prefix_search_stage import pruner_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      advance,

    // From stage 0
    input  wire      s0_valid,
    input  row_idx_t s0_row,
    input  no_t      s0_no,
    input  pattern_t s0_spikes,

    // Whole tables
    input  no_t      no_all     [0:`PRUNER_ROWS-1],
    input  pattern_t spikes_all [0:`PRUNER_ROWS-1],

    // Stage 1 registers
    output logic     s1_valid,
    output row_idx_t s1_row,
    output pattern_t s1_spikes,
    output row_idx_t s1_prefix,
    output pattern_t s1_prefix_spikes
);

    logic     cand     [0:`PRUNER_ROWS-1];
    logic     found;
    row_idx_t best_idx;
    no_t      best_no;
    pattern_t best_spikes;

    // Candidate test for every table row
    always_comb begin
        for (int j = 0; j < `PRUNER_ROWS; j++) begin
            cand[j] = 1'b0;
            if (row_idx_t'(j) != s0_row) begin
                // Partial match, proper subset with a smaller count
                if ((no_all[j] < s0_no) &&
                    ((spikes_all[j] & s0_spikes) == spikes_all[j]) &&
                    (spikes_all[j] != s0_spikes)) begin
                    cand[j] = 1'b1;
                end
                // Exact match, only an earlier row qualifies
                if ((no_all[j] == s0_no) &&
                    (spikes_all[j] == s0_spikes) &&
                    (row_idx_t'(j) < s0_row)) begin
                    cand[j] = 1'b1;
                end
            end
        end
    end

    // Largest count wins
    // Scanning upward with >= lets the larger index win a tie
    always_comb begin
        found       = 1'b0;
        best_idx    = s0_row;
        best_no     = '0;
        best_spikes = '0;
        for (int j = 0; j < `PRUNER_ROWS; j++) begin
            if (cand[j] && (!found || no_all[j] >= best_no)) begin
                found       = 1'b1;
                best_idx    = row_idx_t'(j);
                best_no     = no_all[j];
                best_spikes = spikes_all[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= s0_valid;
        end
    end

    // Root rows carry themselves as prefix and a zero prefix pattern
    always_ff @(posedge clk) begin
        if (advance && s0_valid) begin
            s1_row           <= s0_row;
            s1_spikes        <= s0_spikes;
            s1_prefix        <= best_idx;
            s1_prefix_spikes <= best_spikes;
        end
    end

endmodule

`default_nettype wire

// File: logic/row_latch_stage.sv
// Stage 0, row latch

`include "pruner_consts.svh"

`default_nettype none

module row_latch_stage import pruner_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    // Global advance, low while the output is held
    input  wire      advance,

    // Incoming row
    input  wire      row_valid,
    input  row_idx_t row_index,
    input  no_t      row_no,

    // Spike matrix view
    input  pattern_t spikes_all [0:`PRUNER_ROWS-1],

    // Stage 0 registers
    output logic     s0_valid,
    output row_idx_t s0_row,
    output no_t      s0_no,
    output pattern_t s0_spikes
);

    // Valid bit, follows the input only when the pipe moves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s0_valid <= 1'b0;
        end else if (advance) begin
            s0_valid <= row_valid;
        end
    end

    // Row payload plus its pattern from the matrix
    always_ff @(posedge clk) begin
        if (advance && row_valid) begin
            s0_row    <= row_index;
            s0_no     <= row_no;
            s0_spikes <= spikes_all[row_index];
        end
    end

endmodule

`default_nettype wire

// File: logic/row_tables.sv
// Count table and spike matrix

`include "pruner_consts.svh"

`default_nettype none

module row_tables import pruner_pkg::*; (
    input  wire        clk,

    // Shared memory port
    input  row_idx_t   mem_addr,
    input  table_sel_e mem_sel,
    input  wire        mem_wr_en,
    input  no_t        mem_no_in,
    input  pattern_t   mem_spike_in,
    output no_t        mem_no_out,
    output pattern_t   mem_spike_out,

    // Whole tables for the search
    output no_t        no_all     [0:`PRUNER_ROWS-1],
    output pattern_t   spikes_all [0:`PRUNER_ROWS-1]
);

    no_t      no_table     [0:`PRUNER_ROWS-1];
    pattern_t spike_matrix [0:`PRUNER_ROWS-1];

    // One write per cycle into the selected table
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            if (mem_sel == TABLE_NO) begin
                no_table[mem_addr] <= mem_no_in;
            end else begin
                spike_matrix[mem_addr] <= mem_spike_in;
            end
        end
    end

    // Readback with zero on the unselected side
    always_comb begin
        mem_no_out    = '0;
        mem_spike_out = '0;
        if (mem_sel == TABLE_NO) begin
            mem_no_out = no_table[mem_addr];
        end else begin
            mem_spike_out = spike_matrix[mem_addr];
        end
    end

    // Every entry in parallel
    assign no_all     = no_table;
    assign spikes_all = spike_matrix;

endmodule

`default_nettype wire

// File: logic/pruner_pkg.sv
// Row pruner types

`include "pruner_consts.svh"

`default_nettype none

package pruner_pkg;

    // Row index into either table
    typedef logic [`PRUNER_IDX_W-1:0] row_idx_t;

    // Spike pattern, also used for the residual
    typedef logic [`PRUNER_PATTERN_W-1:0] pattern_t;

    // Spike count of one row
    typedef logic [`PRUNER_NO_W-1:0] no_t;

    // Accepted output counter
    typedef logic [`PRUNER_CNT_W-1:0] out_count_t;

    // Target of the shared memory port
    typedef enum logic {
        TABLE_NO    = 1'b0,
        TABLE_SPIKE = 1'b1
    } table_sel_e;

endpackage

`default_nettype wire

// File: logic/pruner_consts.svh
// Row pruner constants

`ifndef PRUNER_CONSTS_SVH
`define PRUNER_CONSTS_SVH

// Table rows (N)
// Kept small for simulation, the logic scales to 256
`define PRUNER_ROWS 32

// Spike pattern width (M)
`define PRUNER_PATTERN_W 16

// Spike count width
`define PRUNER_NO_W 8

// Row index width
`define PRUNER_IDX_W $clog2(`PRUNER_ROWS)

// Output counter width, must hold N itself
`define PRUNER_CNT_W $clog2(`PRUNER_ROWS + 1)

`endif
